/* hw/fetch_cfg_pkg.sv */
// Memory map, reset vector and buffer sizing shared by the fetch stage and its testbench
package fetch_cfg_pkg;

    // Scratch instruction memory region
    localparam logic [31:0] scratch_base = 32'h8000_0000;
    localparam int scratch_words = 256;
    localparam int scratch_addr_w = 8;

    // Fetch restarts here after reset and after an exception
    localparam logic [31:0] reset_vec = scratch_base;

    // Instruction buffer sizing
    localparam int ib_depth = 4;
    localparam int ib_count_w = 3;
    localparam int ib_ptr_w = 2;

    // Early-full rises one entry short of full, so a fetch already in
    // flight still has a slot when it lands
    localparam int ib_early_level = ib_depth - 1;

endpackage

/* hw/rv_isa_pkg.sv */
// RISC-V major opcodes and instruction field positions for early decode and the testbench model
package rv_isa_pkg;

    // RV32 major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        lui       = 7'b0110111,
        auipc     = 7'b0010111,
        jal       = 7'b1101111,
        jalr      = 7'b1100111,
        branch    = 7'b1100011,
        load      = 7'b0000011,
        store     = 7'b0100011,
        arith_imm = 7'b0010011,
        arith     = 7'b0110011,
        fence     = 7'b0001111,
        system    = 7'b1110011,
        amo       = 7'b0101111
    } opcode_t;

    // Field positions inside a 32-bit instruction word
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;
    localparam int rd_lsb = 7;
    localparam int rd_msb = 11;
    localparam int funct3_lsb = 12;
    localparam int funct3_msb = 14;
    localparam int rs1_lsb = 15;
    localparam int rs1_msb = 19;
    localparam int rs2_lsb = 20;
    localparam int rs2_msb = 24;

endpackage

/* hw/fetch_ctrl.sv */
// Fetch control deciding request issue and flush and tracking the stage-2 entry, used by fetch_top
module fetch_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        exception,
    input  logic        redirect,
    input  logic        load_en,
    input  logic [31:0] fetch_pc,
    input  logic        early_full,
    input  logic        full,
    output logic        fetch_req,
    output logic        flush,
    output logic        pc_sel_exc,
    output logic        pc_sel_redir,
    output logic        rd_en,
    output logic        push,
    output logic [31:0] push_pc,
    output logic        push_fault
);

    logic        pc_valid;
    logic        room;
    logic [31:0] pc_offset;
    logic        in_range;

    logic        stage2_valid;
    logic [31:0] stage2_pc;
    logic        stage2_fault;

    // Goes high one cycle after reset release and stays there
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= 1'b1;
        end
    end

    // Exception outranks a redirect when selecting the new PC
    assign flush = exception | redirect;
    assign pc_sel_exc = exception;
    assign pc_sel_redir = redirect;

    // An entry in stage 2 will land next cycle, so leave a slot for it
    assign room = stage2_valid ? ~early_full : ~full;

    assign fetch_req = pc_valid & ~flush & ~load_en & room;

    // Addresses below the base wrap to large offsets and fall out of range
    assign pc_offset = fetch_pc - fetch_cfg_pkg::scratch_base;
    assign in_range = pc_offset < (fetch_cfg_pkg::scratch_words * 4);

    // Out-of-range fetches skip the memory read
    assign rd_en = fetch_req & in_range;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage2_valid <= 1'b0;
        end else begin
            stage2_valid <= fetch_req;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            stage2_pc <= fetch_pc;
            stage2_fault <= ~in_range;
        end
    end

    // A flush drops the fetch still in flight
    assign push = stage2_valid & ~flush;
    assign push_pc = stage2_pc;
    assign push_fault = stage2_fault;

endmodule

/* hw/pc_gen.sv */
// Fetch PC register with next-PC selection between reset vector, redirect target and PC plus 4
module pc_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_req,
    input  logic        flush,
    input  logic        pc_sel_exc,
    input  logic        pc_sel_redir,
    input  logic [31:0] redirect_pc,
    output logic [31:0] fetch_pc
);

    logic [31:0] next_pc;

    // Exception first, then redirect, then sequential
    always_comb begin
        if (pc_sel_exc) begin
            next_pc = fetch_cfg_pkg::reset_vec;
        end else if (pc_sel_redir) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = fetch_pc + 32'd4;
        end
    end

    // PC only moves on a new request or a flush, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= fetch_cfg_pkg::reset_vec;
        end else if (fetch_req | flush) begin
            fetch_pc <= {next_pc[31:2], 2'b00};
        end
    end

endmodule

/* hw/scratch_imem.sv */
// Scratch instruction memory with registered read and a load port for filling it
module scratch_imem (
    input  logic                                    clk,
    input  logic                                    rd_en,
    input  logic [fetch_cfg_pkg::scratch_addr_w-1:0] rd_addr,
    output logic [31:0]                             rd_data,
    input  logic                                    load_en,
    input  logic [fetch_cfg_pkg::scratch_addr_w-1:0] load_addr,
    input  logic [31:0]                             load_data
);

    logic [31:0] mem [fetch_cfg_pkg::scratch_words];

    // Memory powers up cleared
    initial begin
        for (int i = 0; i < fetch_cfg_pkg::scratch_words; i++) begin
            mem[i] = 32'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* hw/early_decode.sv */
// Early decode of register usage for the word entering the instruction buffer
module early_decode (
    input  logic [31:0] instr,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output logic        uses_rd
);

    rv_isa_pkg::opcode_t opcode;
    logic [2:0]          funct3;
    logic [4:0]          rd;

    logic csr_imm_op;
    logic sys_op;
    logic jal_jalr_x0;

    assign opcode = rv_isa_pkg::opcode_t'(instr[rv_isa_pkg::opcode_msb:rv_isa_pkg::opcode_lsb]);
    assign funct3 = instr[rv_isa_pkg::funct3_msb:rv_isa_pkg::funct3_lsb];
    assign rd = instr[rv_isa_pkg::rd_msb:rv_isa_pkg::rd_lsb];

    // CSR ops with an immediate source, and ecall/ebreak/xret style ops
    assign csr_imm_op = (opcode == rv_isa_pkg::system) && funct3[2];
    assign sys_op = (opcode == rv_isa_pkg::system) && (funct3 == 3'b000);

    // Plain jumps that discard the link address
    assign jal_jalr_x0 = ((opcode == rv_isa_pkg::jal) || (opcode == rv_isa_pkg::jalr))
                         && (rd == 5'd0);

    assign uses_rs1 = !((opcode == rv_isa_pkg::lui) ||
                        (opcode == rv_isa_pkg::auipc) ||
                        (opcode == rv_isa_pkg::jal) ||
                        (opcode == rv_isa_pkg::fence) ||
                        csr_imm_op || sys_op);

    assign uses_rs2 = (opcode == rv_isa_pkg::branch) ||
                      (opcode == rv_isa_pkg::store) ||
                      (opcode == rv_isa_pkg::arith) ||
                      (opcode == rv_isa_pkg::amo);

    assign uses_rd = !((opcode == rv_isa_pkg::branch) ||
                       (opcode == rv_isa_pkg::store) ||
                       (opcode == rv_isa_pkg::fence) ||
                       sys_op || jal_jalr_x0);

endmodule

/* hw/instr_buffer.sv */
// Circular FIFO of fetched entries with full and early-full levels for fetch back-pressure
module instr_buffer (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  logic        flush,
    input  logic        pop,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_pc,
    input  logic        in_fault,
    input  logic        in_uses_rs1,
    input  logic        in_uses_rs2,
    input  logic        in_uses_rd,
    output logic        valid,
    output logic [31:0] out_instr,
    output logic [31:0] out_pc,
    output logic        out_fault,
    output logic        out_uses_rs1,
    output logic        out_uses_rs2,
    output logic        out_uses_rd,
    output logic        full,
    output logic        early_full
);

    logic [31:0] instr_q [fetch_cfg_pkg::ib_depth];
    logic [31:0] pc_q [fetch_cfg_pkg::ib_depth];
    logic [3:0]  flags_q [fetch_cfg_pkg::ib_depth];

    logic [fetch_cfg_pkg::ib_ptr_w-1:0]   wr_ptr;
    logic [fetch_cfg_pkg::ib_ptr_w-1:0]   rd_ptr;
    logic [fetch_cfg_pkg::ib_count_w-1:0] count;

    logic do_push;
    logic do_pop;

    assign valid = count != '0;
    assign full = count == fetch_cfg_pkg::ib_count_w'(fetch_cfg_pkg::ib_depth);
    assign early_full = count >= fetch_cfg_pkg::ib_count_w'(fetch_cfg_pkg::ib_early_level);

    // Pop on an empty buffer is ignored
    assign do_pop = pop & valid;
    assign do_push = push & (~full | do_pop);

    // Flush wins over any push or pop in the same cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            instr_q[wr_ptr] <= in_instr;
            pc_q[wr_ptr] <= in_pc;
            flags_q[wr_ptr] <= {in_fault, in_uses_rs1, in_uses_rs2, in_uses_rd};
        end
    end

    // Head entry
    assign out_instr = instr_q[rd_ptr];
    assign out_pc = pc_q[rd_ptr];
    assign {out_fault, out_uses_rs1, out_uses_rs2, out_uses_rd} = flags_q[rd_ptr];

endmodule

/* hw/fetch_top.sv */
// Top level of the instruction fetch stage, wiring control, PC, memory, decode and buffer
module fetch_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    exception,
    input  logic                                    redirect,
    input  logic [31:0]                             redirect_pc,
    input  logic                                    ib_pop,
    input  logic                                    load_en,
    input  logic [fetch_cfg_pkg::scratch_addr_w-1:0] load_addr,
    input  logic [31:0]                             load_data,
    output logic                                    ib_valid,
    output logic [31:0]                             ib_instr,
    output logic [31:0]                             ib_pc,
    output logic                                    ib_fault,
    output logic                                    ib_uses_rs1,
    output logic                                    ib_uses_rs2,
    output logic                                    ib_uses_rd,
    output logic [31:0]                             fetch_pc
);

    logic fetch_req;
    logic flush;
    logic pc_sel_exc;
    logic pc_sel_redir;
    logic rd_en;
    logic push;
    logic [31:0] push_pc;
    logic push_fault;
    logic full;
    logic early_full;

    logic [31:0] pc_offset;
    logic [fetch_cfg_pkg::scratch_addr_w-1:0] rd_addr;
    logic [31:0] rd_data;
    logic [31:0] push_instr;

    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;

    fetch_ctrl u_fetch_ctrl (
        .clk(clk), .rst(rst), .exception(exception), .redirect(redirect),
        .load_en(load_en), .fetch_pc(fetch_pc), .early_full(early_full), .full(full),
        .fetch_req(fetch_req), .flush(flush), .pc_sel_exc(pc_sel_exc),
        .pc_sel_redir(pc_sel_redir), .rd_en(rd_en), .push(push),
        .push_pc(push_pc), .push_fault(push_fault)
    );

    pc_gen u_pc_gen (
        .clk(clk), .rst(rst), .fetch_req(fetch_req), .flush(flush),
        .pc_sel_exc(pc_sel_exc), .pc_sel_redir(pc_sel_redir),
        .redirect_pc(redirect_pc), .fetch_pc(fetch_pc)
    );

    // Word index within the scratch region
    assign pc_offset = fetch_pc - fetch_cfg_pkg::scratch_base;
    assign rd_addr = pc_offset[fetch_cfg_pkg::scratch_addr_w+1:2];

    scratch_imem u_scratch_imem (
        .clk(clk), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    // Faulting fetches carry a zero instruction
    assign push_instr = push_fault ? 32'h0 : rd_data;

    early_decode u_early_decode (
        .instr(push_instr), .uses_rs1(uses_rs1), .uses_rs2(uses_rs2), .uses_rd(uses_rd)
    );

    instr_buffer u_instr_buffer (
        .clk(clk), .rst(rst), .push(push), .flush(flush), .pop(ib_pop),
        .in_instr(push_instr), .in_pc(push_pc), .in_fault(push_fault),
        .in_uses_rs1(uses_rs1), .in_uses_rs2(uses_rs2), .in_uses_rd(uses_rd),
        .valid(ib_valid), .out_instr(ib_instr), .out_pc(ib_pc), .out_fault(ib_fault),
        .out_uses_rs1(ib_uses_rs1), .out_uses_rs2(ib_uses_rs2), .out_uses_rd(ib_uses_rd),
        .full(full), .early_full(early_full)
    );

endmodule

/* verif/fetch_model.svh */
// Reference model for the fetch testbench, included inside the testbench module
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// Mirror of what the load port wrote into scratch memory
logic [31:0] model_mem [fetch_cfg_pkg::scratch_words];

// Major opcodes of every class, plus one that decode does not know
function automatic logic [6:0] class_opcode(int unsigned sel);
    logic [6:0] ops [13];
    ops = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011, 7'b0000011,
            7'b0100011, 7'b0010011, 7'b0110011, 7'b0001111, 7'b1110011, 7'b0101111,
            7'b1111111};
    return ops[sel % 13];
endfunction

function automatic logic [31:0] random_instr();
    logic [31:0] word;
    word = $urandom;
    word[rv_isa_pkg::opcode_msb:rv_isa_pkg::opcode_lsb] = class_opcode($urandom_range(12, 0));
    // Zero rd and funct3 now and then to reach the jump and system corners
    if ($urandom_range(3, 0) == 0)
        word[rv_isa_pkg::rd_msb:rv_isa_pkg::rd_lsb] = 5'd0;
    if ($urandom_range(3, 0) == 0)
        word[rv_isa_pkg::funct3_msb:rv_isa_pkg::funct3_lsb] = 3'd0;
    return word;
endfunction

function automatic logic in_scratch(logic [31:0] pc);
    return (pc >= fetch_cfg_pkg::scratch_base) &&
           (pc - fetch_cfg_pkg::scratch_base < fetch_cfg_pkg::scratch_words * 4);
endfunction

// Word expected in the entry for a PC, zero for the fault region
function automatic logic [31:0] expected_instr(logic [31:0] pc);
    logic [31:0] offset;
    offset = pc - fetch_cfg_pkg::scratch_base;
    if (!in_scratch(pc))
        return 32'h0;
    return model_mem[offset[fetch_cfg_pkg::scratch_addr_w+1:2]];
endfunction

// Flags as {uses_rs1, uses_rs2, uses_rd}
function automatic logic [2:0] expected_flags(logic [31:0] instr);
    logic [2:0] f3;
    logic       rd_zero;
    logic       rs1_used;
    logic       rs2_used;
    logic       rd_used;
    f3 = instr[rv_isa_pkg::funct3_msb:rv_isa_pkg::funct3_lsb];
    rd_zero = instr[rv_isa_pkg::rd_msb:rv_isa_pkg::rd_lsb] == 5'd0;
    rs1_used = 1'b1;
    rs2_used = 1'b0;
    rd_used = 1'b1;
    case (instr[rv_isa_pkg::opcode_msb:rv_isa_pkg::opcode_lsb])
        7'b0110111, 7'b0010111: rs1_used = 1'b0;
        7'b1101111: begin
            rs1_used = 1'b0;
            rd_used = !rd_zero;
        end
        7'b1100111: rd_used = !rd_zero;
        7'b1100011, 7'b0100011: begin
            rs2_used = 1'b1;
            rd_used = 1'b0;
        end
        7'b0110011, 7'b0101111: rs2_used = 1'b1;
        7'b0001111: begin
            rs1_used = 1'b0;
            rd_used = 1'b0;
        end
        7'b1110011: begin
            // Plain system ops use neither, CSR-immediate ops skip rs1
            if (f3 == 3'd0) begin
                rs1_used = 1'b0;
                rd_used = 1'b0;
            end else if (f3[2]) begin
                rs1_used = 1'b0;
            end
        end
        default: ;
    endcase
    return {rs1_used, rs2_used, rd_used};
endfunction

// Where fetch restarts after a flush
function automatic logic [31:0] flush_target(logic exc, logic [31:0] target);
    if (exc)
        return fetch_cfg_pkg::reset_vec;
    return {target[31:2], 2'b00};
endfunction

`endif

/* verif/fetch_tb.sv */
// Testbench for the fetch stage that loads random code and then runs random pops, redirects and exceptions
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 40;
    localparam int reset_cycles = 10;
    localparam int random_cycles = 4000;
    localparam int margin_cycles = 600;
    localparam int total_cycles = reset_cycles + fetch_cfg_pkg::scratch_words +
                                  random_cycles + margin_cycles;

    logic        clk;
    logic        rst;
    logic        exception;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        ib_pop;
    logic        load_en;
    logic [fetch_cfg_pkg::scratch_addr_w-1:0] load_addr;
    logic [31:0] load_data;
    logic        ib_valid;
    logic [31:0] ib_instr;
    logic [31:0] ib_pc;
    logic        ib_fault;
    logic        ib_uses_rs1;
    logic        ib_uses_rs2;
    logic        ib_uses_rd;
    logic [31:0] fetch_pc;

    int          checks;
    int          errors;
    int          popped;
    int          faults_seen;
    int          flushes;
    logic [31:0] exp_pc;

    `include "fetch_model.svh"

    fetch_top u_fetch_top (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(total_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the run did not complete", total_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic check_condition(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s at %0t", what, $time);
        end
    endtask

    // Head entry against the model, called while the pop is pending
    task automatic check_entry();
        logic [31:0] want_instr;
        logic [2:0]  want_flags;
        want_instr = expected_instr(exp_pc);
        want_flags = expected_flags(want_instr);
        check_value("ib_pc", ib_pc, exp_pc);
        check_value("ib_instr", ib_instr, want_instr);
        check_value("ib_fault", 32'(ib_fault), 32'(!in_scratch(exp_pc)));
        check_value("ib_uses_rs1", 32'(ib_uses_rs1), 32'(want_flags[2]));
        check_value("ib_uses_rs2", 32'(ib_uses_rs2), 32'(want_flags[1]));
        check_value("ib_uses_rd", 32'(ib_uses_rd), 32'(want_flags[0]));
        popped++;
        if (ib_fault)
            faults_seen++;
    endtask

    // Mix of in-range, near-top and out-of-range redirect targets
    function automatic logic [31:0] random_target();
        int unsigned kind;
        kind = $urandom_range(6, 0);
        if (kind == 0)
            return fetch_cfg_pkg::scratch_base + fetch_cfg_pkg::scratch_words * 4 +
                   ($urandom_range(255, 0) << 2);
        if (kind == 1)
            return 32'h0000_4000 + ($urandom_range(255, 0) << 2);
        if (kind == 2)
            return fetch_cfg_pkg::scratch_base +
                   ((fetch_cfg_pkg::scratch_words - 1 - $urandom_range(3, 0)) << 2);
        return fetch_cfg_pkg::scratch_base +
               ($urandom_range(fetch_cfg_pkg::scratch_words - 1, 0) << 2);
    endfunction

    initial begin
        int          stall_left;
        int          since_flush;
        int          cycles_to_valid;
        logic        flush_watch;
        logic        do_exc;
        logic        do_redir;
        logic        do_pop;
        logic        do_load;
        logic [31:0] target;
        void'($urandom(32'h502c));
        rst = 1'b1;
        exception = 1'b0;
        redirect = 1'b0;
        redirect_pc = 32'h0;
        ib_pop = 1'b0;
        load_en = 1'b1;
        load_addr = '0;
        load_data = 32'h0;
        checks = 0;
        errors = 0;
        popped = 0;
        faults_seen = 0;
        flushes = 0;
        repeat (reset_cycles) @(negedge clk);
        check_value("ib_valid", 32'(ib_valid), 32'h0);
        check_value("fetch_pc", fetch_pc, fetch_cfg_pkg::reset_vec);
        rst = 1'b0;

        // Fill the whole memory while fetch is held off
        for (int i = 0; i < fetch_cfg_pkg::scratch_words; i++) begin
            model_mem[i] = random_instr();
            load_addr = fetch_cfg_pkg::scratch_addr_w'(i);
            load_data = model_mem[i];
            @(negedge clk);
        end
        check_value("ib_valid", 32'(ib_valid), 32'h0);
        check_value("fetch_pc", fetch_pc, fetch_cfg_pkg::reset_vec);
        load_en = 1'b0;

        // One cycle to issue, one to read
        cycles_to_valid = 0;
        while (!ib_valid && cycles_to_valid < 10) begin
            @(negedge clk);
            cycles_to_valid++;
        end
        check_condition(ib_valid, "No entry reached the buffer after fetch was released");
        check_value("first entry latency", cycles_to_valid, 32'd2);
        exp_pc = fetch_cfg_pkg::reset_vec;

        stall_left = 0;
        since_flush = 0;
        flush_watch = 1'b0;
        for (int cyc = 0; cyc < random_cycles; cyc++) begin
            // Target fetch issues the cycle after the flush and lands one cycle later
            if (flush_watch) begin
                since_flush++;
                if (since_flush <= 2) begin
                    check_condition(!ib_valid, "Buffer holds an entry too early after a flush");
                end else begin
                    check_condition(ib_valid, "Target entry missing three cycles after a flush");
                    flush_watch = 1'b0;
                end
            end
            do_exc = $urandom_range(149, 0) == 0;
            do_redir = $urandom_range(39, 0) == 0;
            if (do_exc && $urandom_range(1, 0) == 0)
                do_redir = 1'b1;
            do_load = !do_exc && !do_redir && $urandom_range(49, 0) == 0;
            // Long stalls fill the buffer and exercise back-pressure
            if (stall_left > 0) begin
                stall_left--;
                do_pop = 1'b0;
            end else if ($urandom_range(59, 0) == 0) begin
                stall_left = $urandom_range(40, 8);
                do_pop = 1'b0;
            end else begin
                do_pop = $urandom_range(3, 0) != 0;
            end
            target = random_target() | 32'($urandom_range(3, 0));

            if (do_pop && ib_valid && !(do_exc || do_redir)) begin
                check_entry();
                exp_pc = exp_pc + 32'd4;
            end
            if (do_exc || do_redir) begin
                exp_pc = flush_target(do_exc, target);
                since_flush = 0;
                flush_watch = 1'b1;
                flushes++;
            end
            if (do_load)
                flush_watch = 1'b0;

            exception = do_exc;
            redirect = do_redir;
            redirect_pc = do_redir ? target : $urandom;
            ib_pop = do_pop;
            // Rewrites a word with its own value, so only the hold-off is visible
            load_en = do_load;
            load_addr = fetch_cfg_pkg::scratch_addr_w'($urandom);
            load_data = model_mem[load_addr];
            @(negedge clk);
        end

        check_condition(popped > 500, "Too few entries were popped during the random run");
        check_condition(faults_seen > 0, "No fault entry was popped during the random run");
        $display("Checks: %0d, errors: %0d, popped: %0d, faults: %0d, flushes: %0d",
                 checks, errors, popped, faults_seen, flushes);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* tb.f */
+incdir+verif
hw/fetch_cfg_pkg.sv
hw/rv_isa_pkg.sv
hw/fetch_ctrl.sv
hw/pc_gen.sv
hw/scratch_imem.sv
hw/early_decode.sv
hw/instr_buffer.sv
hw/fetch_top.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the fetch testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module fetch_tb -f tb.f -o fetch_sim > sim.log 2>&1 \
    && ./obj_dir/fetch_sim >> sim.log 2>&1

cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && exit 0 || exit 1
